//--- dmb_trig_top.f
dmb_trig_pkg.sv
reset_seq.sv
cal_pulse.sv
trig_encoder.sv
trg_timer.sv
dmb_trig_top.sv
dmb_trig_props.sv
dmb_trig_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dmb_trig_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module dmb_trig_top_tb -f dmb_trig_top.f -o dmb_trig_sim \
	|| { echo "Build failed"; exit 1; }

./obj_dir/dmb_trig_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "Run passed" \
	|| { echo "Run failed"; exit 1; }

//--- dmb_trig_top_tb.sv
`timescale 1ns/1ns

module dmb_trig_top_tb
	import dmb_trig_pkg::*;
();

	localparam int READY_CYCLES    = 64;
	localparam int POH_CYCLES      = 64;
	localparam int LCT_W           = 10;
	localparam int DAV_W           = 6;
	// Two synchronizer stages on the calibration lines
	localparam int CAL_SYNC        = 2;
	// Tests take about 800 cycles, limit is five times that
	localparam int TIMEOUT_CYCLES  = 4000;

	logic             clkcms;
	logic             clr0;
	logic             fpgaready_i;
	logic             resync_i;
	trig_in_t         trig_i;
	trig_cfg_t        cfg_i;
	cal_cmd_t         cal_n_i;
	logic             dav_i;
	logic             dpush_i;
	logic             tmr_clear_i;
	trig_enc_t        trg_enc_o;
	logic             inj_pulse_o;
	logic             ext_pulse_o;
	logic             pedestal_o;
	logic             ctrl_ready_o;
	logic [LCT_W-1:0] lct_l1a_time_o;
	logic [DAV_W-1:0] dav_push_time_o;

	int        cyc_cnt = 0;
	int        n_checks = 0;
	int        n_err = 0;
	int        n_tests = 0;
	int        err_at_start = 0;
	string     cur_test = "init";
	logic      enc_chk_on = 1'b0;
	trig_enc_t enc_hist1 = '0;
	trig_enc_t enc_hist2 = '0;

	dmb_trig_top #(
		.POH_CYCLES(POH_CYCLES)
	)
	dmb_trig_top_i (
		.clkcms         (clkcms),
		.clr0           (clr0),
		.fpgaready_i    (fpgaready_i),
		.resync_i       (resync_i),
		.trig_i         (trig_i),
		.cfg_i          (cfg_i),
		.cal_n_i        (cal_n_i),
		.dav_i          (dav_i),
		.dpush_i        (dpush_i),
		.tmr_clear_i    (tmr_clear_i),
		.trg_enc_o      (trg_enc_o),
		.inj_pulse_o    (inj_pulse_o),
		.ext_pulse_o    (ext_pulse_o),
		.pedestal_o     (pedestal_o),
		.ctrl_ready_o   (ctrl_ready_o),
		.lct_l1a_time_o (lct_l1a_time_o),
		.dav_push_time_o(dav_push_time_o)
	);

	initial
	begin
		clkcms = 1'b0;
		forever #20 clkcms = ~clkcms;
	end

	always @(posedge clkcms)
	begin
		cyc_cnt <= cyc_cnt + 1;
	end

	initial
	begin
		wait (cyc_cnt >= TIMEOUT_CYCLES);
		$display("Timeout: run still going after %0d cycles, in test %s",
			TIMEOUT_CYCLES, cur_test);
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////////////////////

	// Code planes from the per-board priority list, or the raw bits
	function automatic trig_enc_t code_planes(trig_in_t t, logic rs, logic en);
		trig_enc_t  e;
		trig_code_e c;
		e = '0;
		for (int i = 0; i < NUM_FEB; i++)
		begin
			if (!en)
			begin
				e.b0[i] = t.pre_lct[i];
				e.b1[i] = t.l1a & t.l1a_match[i];
			end
			else
			begin
				if (rs)
					c = CODE_RESYNC;
				else if (t.l1a)
					c = t.l1a_match[i] ? CODE_L1A_MATCH : CODE_L1A_NOMATCH;
				else
					c = t.pre_lct[i] ? CODE_PRE_LCT : CODE_IDLE;
				e.b0[i] = c[0];
				e.b1[i] = c[1];
				e.b2[i] = c[2];
			end
		end
		return e;
	endfunction

	// Start-to-stop gap, saturated at the counter width
	function automatic int saturated_gap(int gap, int width);
		int max_val;
		max_val = (1 << width) - 1;
		return (gap > max_val) ? max_val : gap;
	endfunction

	function automatic logic [11:0] pulse_mask(int dly, int len);
		logic [11:0] w;
		for (int k = 0; k < 12; k++)
			w[k] = (k >= dly) && (k < dly + len);
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checking and reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		assert (act === exp)
		else
		begin
			n_err++;
			$display("** Error [%s] %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test     = name;
		err_at_start = n_err;
	endtask

	task automatic end_test();
		n_tests++;
		if (n_err == err_at_start)
			$display("test %s: ok", cur_test);
		else
			$display("test %s: %0d error(s)", cur_test, n_err - err_at_start);
	endtask

	// Encoder compare, output lags the inputs by one or two cycles
	always @(negedge clkcms)
	begin
		if (enc_chk_on)
			check_val("trg_enc_o", 32'(cfg_i.cable_dly ? enc_hist2 : enc_hist1),
				32'(trg_enc_o));
		enc_hist2 = enc_hist1;
		enc_hist1 = code_planes(trig_i, resync_i, cfg_i.encode_en);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clkcms);
	endtask

	task automatic encode_phase(input logic en, input logic dly, input int n, input bit with_rs);
		@(posedge clkcms);
		cfg_i.encode_en <= en;
		cfg_i.cable_dly <= dly;
		trig_i          <= '0;
		resync_i        <= 1'b0;
		wait_cycles(3);
		enc_chk_on <= 1'b1;
		repeat (n)
		begin
			trig_i   <= trig_in_t'(12'($urandom));
			resync_i <= with_rs && ($urandom % 8 == 0);
			@(posedge clkcms);
		end
		trig_i   <= '0;
		resync_i <= 1'b0;
		// Drain the pipeline before checking stops
		wait_cycles(3);
		enc_chk_on <= 1'b0;
	endtask

	task automatic pulse_window(input cal_cmd_t act, input int len,
		output logic [11:0] inj_w, output logic [11:0] ext_w, output logic [11:0] ped_w);
		@(posedge clkcms);
		cal_n_i <= cal_cmd_t'(~act);
		for (int k = 0; k < 12; k++)
		begin
			@(negedge clkcms);
			inj_w[k] = inj_pulse_o;
			ext_w[k] = ext_pulse_o;
			ped_w[k] = pedestal_o;
			@(posedge clkcms);
			if (k + 1 == len)
				cal_n_i <= '1;
		end
	endtask

	// One start pulse, then a stop pulse gap cycles later
	task automatic run_timer(input bit dav, input int gap);
		@(posedge clkcms);
		if (dav)
			dav_i <= 1'b1;
		else
			trig_i.lct_any <= 1'b1;
		@(posedge clkcms);
		dav_i          <= 1'b0;
		trig_i.lct_any <= 1'b0;
		wait_cycles(gap - 1);
		if (dav)
			dpush_i <= 1'b1;
		else
			trig_i.l1a <= 1'b1;
		@(posedge clkcms);
		dpush_i    <= 1'b0;
		trig_i.l1a <= 1'b0;
		@(negedge clkcms);
	endtask

	initial
	begin
		int               gap;
		int               n;
		logic             rose;
		logic [11:0]      inj_w;
		logic [11:0]      ext_w;
		logic [11:0]      ped_w;
		cal_cmd_t         cmd;
		logic [LCT_W-1:0] lct_prev;
		logic [DAV_W-1:0] dav_prev;

		void'($urandom(32'h99f4_ca13));
		clr0        = 1'b1;
		fpgaready_i = 1'b0;
		resync_i    = 1'b0;
		trig_i      = '0;
		cfg_i       = '{encode_en: 1'b1, cable_dly: 1'b0, cal_trg_sel: 1'b0, cal_gate_en: 1'b0};
		cal_n_i     = '1;
		dav_i       = 1'b0;
		dpush_i     = 1'b0;
		tmr_clear_i = 1'b0;
		wait_cycles(3);
		clr0 <= 1'b0;

		begin_test("power_up");
		@(posedge clkcms);
		fpgaready_i <= 1'b1;
		n    = 0;
		rose = 1'b0;
		while (!rose && n < READY_CYCLES + 10)
		begin
			@(posedge clkcms);
			n++;
			@(negedge clkcms);
			check_val("trg_enc_o during power-up", 0, 32'(trg_enc_o));
			rose = ctrl_ready_o;
		end
		n_checks++;
		assert (rose && n >= READY_CYCLES + 2 && n <= READY_CYCLES + 3)
		else
		begin
			n_err++;
			if (!rose)
				$display("ctrl_ready_o never rose after board ready");
			else
				$display("** Error [%s] ctrl_ready_o delay: expected %0d to %0d, actual %0d",
					cur_test, READY_CYCLES + 2, READY_CYCLES + 3, n);
		end
		end_test();

		begin_test("encoding");
		encode_phase(1'b1, 1'b0, 200, 1'b0);
		encode_phase(1'b0, 1'b0, 100, 1'b0);
		end_test();

		begin_test("cable_resync");
		encode_phase(1'b1, 1'b1, 150, 1'b1);
		encode_phase(1'b1, 1'b0, 60, 1'b1);
		end_test();

		begin_test("calibration");
		cmd     = '0;
		cmd.inj = 1'b1;
		pulse_window(cmd, 1, inj_w, ext_w, ped_w);
		check_val("inj_pulse_o window", 32'(pulse_mask(CAL_SYNC, 1)), 32'(inj_w));
		cmd     = '0;
		cmd.pls = 1'b1;
		pulse_window(cmd, 1, inj_w, ext_w, ped_w);
		// Stretch adds one cycle
		check_val("ext_pulse_o window", 32'(pulse_mask(CAL_SYNC, 2)), 32'(ext_w));
		cmd     = '0;
		cmd.ped = 1'b1;
		pulse_window(cmd, 5, inj_w, ext_w, ped_w);
		check_val("pedestal_o window", 32'(pulse_mask(CAL_SYNC, 5)), 32'(ped_w));
		@(posedge clkcms);
		cfg_i.cal_trg_sel <= 1'b1;
		cfg_i.cal_gate_en <= 1'b1;
		cmd     = '0;
		cmd.pls = 1'b1;
		pulse_window(cmd, 1, inj_w, ext_w, ped_w);
		// Gate keeps one of the two stretched cycles
		check_val("gated ext_pulse_o count", 1, $countones(ext_w));
		cfg_i.cal_trg_sel <= 1'b0;
		cfg_i.cal_gate_en <= 1'b0;
		end_test();

		begin_test("timers");
		for (int r = 0; r < 4; r++)
		begin
			gap = 3 + int'($urandom % 38);
			run_timer(1'b0, gap);
			check_val("lct_l1a_time_o", saturated_gap(gap, LCT_W), 32'(lct_l1a_time_o));
			gap = 3 + int'($urandom % 38);
			run_timer(1'b1, gap);
			check_val("dav_push_time_o", saturated_gap(gap, DAV_W), 32'(dav_push_time_o));
		end
		run_timer(1'b1, 70);
		check_val("dav_push_time_o saturated", saturated_gap(70, DAV_W), 32'(dav_push_time_o));
		end_test();

		begin_test("timer_holdoff");
		lct_prev = lct_l1a_time_o;
		dav_prev = dav_push_time_o;
		// Board ready drops and returns, which starts a new holdoff
		@(posedge clkcms);
		fpgaready_i <= 1'b0;
		wait_cycles(4);
		fpgaready_i <= 1'b1;
		wait_cycles(8);
		run_timer(1'b0, 2);
		run_timer(1'b1, 2);
		check_val("lct_l1a_time_o in holdoff", 32'(lct_prev), 32'(lct_l1a_time_o));
		check_val("dav_push_time_o in holdoff", 32'(dav_prev), 32'(dav_push_time_o));
		wait_cycles(POH_CYCLES);
		tmr_clear_i <= 1'b1;
		@(posedge clkcms);
		tmr_clear_i <= 1'b0;
		@(negedge clkcms);
		check_val("lct_l1a_time_o cleared", 0, 32'(lct_l1a_time_o));
		check_val("dav_push_time_o cleared", 0, 32'(dav_push_time_o));
		end_test();

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
		if (n_err == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- dmb_trig_props.sv
`timescale 1ns/1ns

module dmb_trig_props
	import dmb_trig_pkg::*;
#(
	parameter int FPGA_RST_CYCLES = 16
)
(
	input logic      clkcms,
	input logic      clr0,
	input logic      fpga_rst_i,
	input trig_enc_t trg_enc_i,
	input logic      ctrl_ready_i,
	input logic      ext_pulse_i,
	input trig_cfg_t cfg_i
);

	int   rst_len;
	logic gate_on;

	assign gate_on = cfg_i.cal_trg_sel & cfg_i.cal_gate_en;

	// Length of the current FPGA reset pulse
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
			rst_len <= 0;
		else if (fpga_rst_i)
			rst_len <= rst_len + 1;
		else
			rst_len <= 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////////////////////

	enc_clear_a: assert property (@(posedge clkcms) disable iff (clr0)
		fpga_rst_i |-> (trg_enc_i == '0))
		else $error("trigger code nonzero during FPGA reset");

	ready_low_a: assert property (@(posedge clkcms) disable iff (clr0)
		fpga_rst_i |-> !ctrl_ready_i)
		else $error("controller ready high during FPGA reset");

	rst_len_a: assert property (@(posedge clkcms) disable iff (clr0)
		rst_len <= FPGA_RST_CYCLES)
		else $error("FPGA reset longer than %0d cycles", FPGA_RST_CYCLES);

	// Both pulse cycles were formed with the gate on
	ext_gate_a: assert property (@(posedge clkcms) disable iff (clr0)
		(ext_pulse_i && $past(ext_pulse_i)) |-> !($past(gate_on) && $past(gate_on, 2)))
		else $error("external pulse on two cycles in gated mode");

endmodule

bind dmb_trig_top dmb_trig_props #(
	.FPGA_RST_CYCLES(FPGA_RST_CYCLES)
)
dmb_trig_props_i (
	.clkcms      (clkcms),
	.clr0        (clr0),
	.fpga_rst_i  (fpga_rst),
	.trg_enc_i   (trg_enc_o),
	.ctrl_ready_i(ctrl_ready_o),
	.ext_pulse_i (ext_pulse_o),
	.cfg_i       (cfg_i)
);

//--- dmb_trig_top.sv
`timescale 1ns/1ns

module dmb_trig_top
	import dmb_trig_pkg::*;
#(
	parameter int FPGA_RST_CYCLES = 16,
	parameter int READY_CYCLES    = 64,
	parameter int POH_CYCLES      = 256,
	parameter int LCT_TMR_WIDTH   = 10,
	parameter int DAV_TMR_WIDTH   = 6
)
(
	input  logic                     clkcms,
	input  logic                     clr0,
	input  logic                     fpgaready_i,
	input  logic                     resync_i,
	input  trig_in_t                 trig_i,
	input  trig_cfg_t                cfg_i,
	input  cal_cmd_t                 cal_n_i,
	input  logic                     dav_i,
	input  logic                     dpush_i,
	input  logic                     tmr_clear_i,
	output trig_enc_t                trg_enc_o,
	output logic                     inj_pulse_o,
	output logic                     ext_pulse_o,
	output logic                     pedestal_o,
	output logic                     ctrl_ready_o,
	output logic [LCT_TMR_WIDTH-1:0] lct_l1a_time_o,
	output logic [DAV_TMR_WIDTH-1:0] dav_push_time_o
);

	logic fpga_rst;
	logic sys_rst;
	logic holdoff;

	////////////////////////////////////////////////////////////////////////////
	// Resets and holdoff
	////////////////////////////////////////////////////////////////////////////

	reset_seq #(
		.FPGA_RST_CYCLES(FPGA_RST_CYCLES),
		.READY_CYCLES   (READY_CYCLES),
		.POH_CYCLES     (POH_CYCLES)
	)
	reset_seq_i (
		.clkcms      (clkcms),
		.clr0        (clr0),
		.fpgaready_i (fpgaready_i),
		.resync_i    (resync_i),
		.fpga_rst_o  (fpga_rst),
		.sys_rst_o   (sys_rst),
		.ctrl_ready_o(ctrl_ready_o),
		.holdoff_o   (holdoff)
	);

	// Calibration commands
	cal_pulse cal_pulse_i (
		.clkcms       (clkcms),
		.clr0         (clr0),
		.sys_rst_i    (sys_rst),
		.cal_n_i      (cal_n_i),
		.cal_trg_sel_i(cfg_i.cal_trg_sel),
		.cal_gate_en_i(cfg_i.cal_gate_en),
		.inj_pulse_o  (inj_pulse_o),
		.ext_pulse_o  (ext_pulse_o),
		.pedestal_o   (pedestal_o)
	);

	// Trigger codes to the front-end boards
	trig_encoder trig_encoder_i (
		.clkcms     (clkcms),
		.clr0       (clr0),
		.fpga_rst_i (fpga_rst),
		.sys_rst_i  (sys_rst),
		.trig_i     (trig_i),
		.encode_en_i(cfg_i.encode_en),
		.cable_dly_i(cfg_i.cable_dly),
		.trg_enc_o  (trg_enc_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Latency timers
	////////////////////////////////////////////////////////////////////////////

	// LCT to L1A
	trg_timer #(
		.WIDTH(LCT_TMR_WIDTH)
	)
	lct_l1a_tmr_i (
		.clkcms   (clkcms),
		.clr0     (clr0),
		.holdoff_i(holdoff),
		.clear_i  (tmr_clear_i),
		.start_i  (trig_i.lct_any),
		.stop_i   (trig_i.l1a),
		.time_o   (lct_l1a_time_o)
	);

	// Data available to FIFO push
	trg_timer #(
		.WIDTH(DAV_TMR_WIDTH)
	)
	dav_push_tmr_i (
		.clkcms   (clkcms),
		.clr0     (clr0),
		.holdoff_i(holdoff),
		.clear_i  (tmr_clear_i),
		.start_i  (dav_i),
		.stop_i   (dpush_i),
		.time_o   (dav_push_time_o)
	);

endmodule

//--- trg_timer.sv
`timescale 1ns/1ns

module trg_timer #(
	parameter int WIDTH = 10
)
(
	input  logic             clkcms,
	input  logic             clr0,
	input  logic             holdoff_i,
	input  logic             clear_i,
	input  logic             start_i,
	input  logic             stop_i,
	output logic [WIDTH-1:0] time_o
);

	logic             running;
	logic [WIDTH-1:0] cnt;
	logic [WIDTH-1:0] cnt_next;

	// Saturating increment
	assign cnt_next = (cnt == '1) ? cnt : cnt + 1'b1;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			running <= 1'b0;
			cnt     <= '0;
			time_o  <= '0;
		end
		else if (clear_i)
		begin
			running <= 1'b0;
			cnt     <= '0;
			time_o  <= '0;
		end
		else if (start_i && !holdoff_i)
		begin
			// Also restarts a measurement already in progress
			running <= 1'b1;
			cnt     <= '0;
		end
		else if (running)
		begin
			cnt <= cnt_next;
			if (stop_i)
			begin
				time_o  <= cnt_next;
				running <= 1'b0;
			end
		end
	end

endmodule

//--- trig_encoder.sv
`timescale 1ns/1ns

module trig_encoder
	import dmb_trig_pkg::*;
(
	input  logic      clkcms,
	input  logic      clr0,
	input  logic      fpga_rst_i,
	input  logic      sys_rst_i,
	input  trig_in_t  trig_i,
	input  logic      encode_en_i,
	input  logic      cable_dly_i,
	output trig_enc_t trg_enc_o
);

	trig_code_e feb_code [NUM_FEB];
	trig_enc_t  enc_next;
	trig_enc_t  enc_dly;
	trig_enc_t  enc_sel;
	logic       out_clr;

	// Per-board code in priority order
	always_comb
	begin
		for (int i = 0; i < NUM_FEB; i++)
		begin
			if (sys_rst_i)
				feb_code[i] = CODE_RESYNC;
			else if (trig_i.l1a && trig_i.l1a_match[i])
				feb_code[i] = CODE_L1A_MATCH;
			else if (trig_i.l1a)
				feb_code[i] = CODE_L1A_NOMATCH;
			else if (trig_i.pre_lct[i])
				feb_code[i] = CODE_PRE_LCT;
			else
				feb_code[i] = CODE_IDLE;
		end
	end

	// Split codes into bit planes, or pass raw bits when encoding is off
	always_comb
	begin
		if (encode_en_i)
		begin
			for (int i = 0; i < NUM_FEB; i++)
			begin
				enc_next.b0[i] = feb_code[i][0];
				enc_next.b1[i] = feb_code[i][1];
				enc_next.b2[i] = feb_code[i][2];
			end
		end
		else
		begin
			enc_next.b0 = trig_i.pre_lct;
			enc_next.b1 = trig_i.l1a_match & {NUM_FEB{trig_i.l1a}};
			enc_next.b2 = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Cable delay stage and output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
			enc_dly <= '0;
		else
			enc_dly <= enc_next;
	end

	assign enc_sel = cable_dly_i ? enc_dly : enc_next;

	// Output held at zero by board reset and by FPGA reset
	assign out_clr = clr0 | fpga_rst_i;

	always_ff @(posedge clkcms or posedge out_clr)
	begin
		if (out_clr)
			trg_enc_o <= '0;
		else
			trg_enc_o <= enc_sel;
	end

endmodule

//--- cal_pulse.sv
`timescale 1ns/1ns

module cal_pulse
	import dmb_trig_pkg::*;
(
	input  logic     clkcms,
	input  logic     clr0,
	input  logic     sys_rst_i,
	input  cal_cmd_t cal_n_i,
	input  logic     cal_trg_sel_i,
	input  logic     cal_gate_en_i,
	output logic     inj_pulse_o,
	output logic     ext_pulse_o,
	output logic     pedestal_o
);

	cal_cmd_t cal;
	cal_cmd_t cal_s1;
	logic     pls_s2;
	logic     sys_rst_q;
	logic     rst_le;
	logic     alt_en;
	logic     gate_on;

	// Connector lines are active low
	assign cal = cal_cmd_t'(~cal_n_i);

	assign rst_le  = sys_rst_i & ~sys_rst_q;
	assign gate_on = cal_trg_sel_i & cal_gate_en_i;

	// Alternating enable, restarted after every reset edge
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			sys_rst_q <= 1'b0;
			alt_en    <= 1'b0;
		end
		else
		begin
			sys_rst_q <= sys_rst_i;
			alt_en    <= rst_le ? 1'b0 : ~alt_en;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command synchronizing and pulse stretch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			cal_s1      <= '0;
			pls_s2      <= 1'b0;
			inj_pulse_o <= 1'b0;
			pedestal_o  <= 1'b0;
			ext_pulse_o <= 1'b0;
		end
		else
		begin
			cal_s1      <= cal;
			pls_s2      <= cal_s1.pls;
			inj_pulse_o <= cal_s1.inj;
			pedestal_o  <= cal_s1.ped;
			// Two-cycle pulse, every other cycle when gated
			ext_pulse_o <= (cal_s1.pls | pls_s2) & (alt_en | ~gate_on);
		end
	end

endmodule

//--- reset_seq.sv
`timescale 1ns/1ns

module reset_seq #(
	parameter int FPGA_RST_CYCLES = 16,
	parameter int READY_CYCLES    = 64,
	parameter int POH_CYCLES      = 256
)
(
	input  logic clkcms,
	input  logic clr0,
	input  logic fpgaready_i,
	input  logic resync_i,
	output logic fpga_rst_o,
	output logic sys_rst_o,
	output logic ctrl_ready_o,
	output logic holdoff_o
);

	localparam int RST_W = $clog2(FPGA_RST_CYCLES + 1);
	localparam int RDY_W = $clog2(READY_CYCLES + 1);
	localparam int POH_W = $clog2(POH_CYCLES + 1);

	logic             ready_s1;
	logic             ready_s2;
	logic             ready_le;
	logic [RST_W-1:0] rst_cnt;
	logic             rdy_run;
	logic [RDY_W-1:0] rdy_cnt;
	logic [POH_W-1:0] poh_cnt;

	// Board-ready synchronizer
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			ready_s1 <= 1'b0;
			ready_s2 <= 1'b0;
		end
		else
		begin
			ready_s1 <= fpgaready_i;
			ready_s2 <= ready_s1;
		end
	end

	// Edge taken one stage early so the reset starts with stage two
	assign ready_le = ready_s1 & ~ready_s2;

	////////////////////////////////////////////////////////////////////////////
	// FPGA reset pulse, fixed length
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			fpga_rst_o <= 1'b0;
			rst_cnt    <= '0;
		end
		else if (ready_le && !fpga_rst_o)
		begin
			fpga_rst_o <= 1'b1;
			rst_cnt    <= '0;
		end
		else if (fpga_rst_o)
		begin
			if (rst_cnt == RST_W'(FPGA_RST_CYCLES - 1))
			begin
				fpga_rst_o <= 1'b0;
				rst_cnt    <= '0;
			end
			else
				rst_cnt <= rst_cnt + 1'b1;
		end
	end

	// Controller ready, dropped as soon as the board loses ready
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			rdy_run      <= 1'b0;
			rdy_cnt      <= '0;
			ctrl_ready_o <= 1'b0;
		end
		else if (ready_le)
		begin
			rdy_run      <= 1'b1;
			rdy_cnt      <= '0;
			ctrl_ready_o <= 1'b0;
		end
		else if (!ready_s2)
		begin
			rdy_run      <= 1'b0;
			rdy_cnt      <= '0;
			ctrl_ready_o <= 1'b0;
		end
		else if (rdy_run)
		begin
			if (rdy_cnt == RDY_W'(READY_CYCLES - 1))
			begin
				rdy_run      <= 1'b0;
				rdy_cnt      <= '0;
				ctrl_ready_o <= 1'b1;
			end
			else
				rdy_cnt <= rdy_cnt + 1'b1;
		end
	end

	// Power-on holdoff for the latency timers
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			holdoff_o <= 1'b0;
			poh_cnt   <= '0;
		end
		else if (ready_le && !fpga_rst_o)
		begin
			holdoff_o <= 1'b1;
			poh_cnt   <= '0;
		end
		else if (holdoff_o)
		begin
			if (poh_cnt == POH_W'(POH_CYCLES - 1))
				holdoff_o <= 1'b0;
			poh_cnt <= poh_cnt + 1'b1;
		end
	end

	// Resync request joins the FPGA reset
	assign sys_rst_o = fpga_rst_o | resync_i;

endmodule

//--- dmb_trig_pkg.sv
package dmb_trig_pkg;

	// Front-end boards served by one motherboard
	localparam int NUM_FEB = 5;

	// One bit per front-end board
	typedef logic [NUM_FEB-1:0] feb_vec_t;

	////////////////////////////////////////////////////////////////////////////
	// Per-board trigger codes sent down the cable
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		CODE_IDLE        = 3'b000,
		CODE_PRE_LCT     = 3'b001,
		CODE_L1A_NOMATCH = 3'b010,
		CODE_L1A_MATCH   = 3'b011,
		CODE_RESYNC      = 3'b111
	} trig_code_e;

	// Trigger inputs from the trigger control logic
	typedef struct packed {
		feb_vec_t pre_lct;
		feb_vec_t l1a_match;
		logic     l1a;
		logic     lct_any;
	} trig_in_t;

	// Bit-plane form, bit i of each plane belongs to board i
	typedef struct packed {
		feb_vec_t b0;
		feb_vec_t b1;
		feb_vec_t b2;
	} trig_enc_t;

	// Static configuration levels
	typedef struct packed {
		logic encode_en;
		logic cable_dly;
		logic cal_trg_sel;
		logic cal_gate_en;
	} trig_cfg_t;

	// Calibration commands, active low on the connector
	typedef struct packed {
		logic ped;
		logic inj;
		logic pls;
	} cal_cmd_t;

endpackage
